// File: Makefile
TOP = frame_reorder_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee run.log
	@if grep -q "test failed" run.log; then exit 1; fi
	@grep -q "test passed" run.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir run.log

// File: dv/frame_reorder_assert.sv
`timescale 1ns/1ps

module frame_reorder_assert
  import fft_stream_pkg::*;
#(
  parameter int BIT_WIDTH = 16
) (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_rdy,
  input logic                 frame_val,
  input logic                 frame_rdy,
  input logic                 perm_val,
  input ser_state_e           ser_state,
  input logic [BIT_WIDTH-1:0] out_msg,
  input logic                 out_val,
  input logic                 out_rdy
);

  // ==========================================================================
  // reset state and handshake rules
  // ==========================================================================

  reset_state: assert property (@(posedge clk)
    $past(reset) |-> (!out_val && !frame_val && !perm_val && ser_state == SER_LOAD))
    else $error("pipeline not empty after reset");

  out_hold: assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_msg)))
    else $error("output sample changed while stalled");

  // a finished frame waits for the permuter with the input closed.
  in_blocked: assert property (@(posedge clk) disable iff (reset)
    (frame_val && !frame_rdy) |=> (frame_val && !in_rdy))
    else $error("frame dropped or input reopened before handover");

endmodule

// File: dv/frame_reorder_stimulus.txt
# columns: mode (0 pass, 1 bitrev, 2 reverse), 8 input samples, 8 expected output samples
# all values hex, one frame per line, samples unique within a frame
0 0000 1111 2222 3333 4444 5555 6666 7777  0000 1111 2222 3333 4444 5555 6666 7777
1 0000 1111 2222 3333 4444 5555 6666 7777  0000 4444 2222 6666 1111 5555 3333 7777
2 0000 1111 2222 3333 4444 5555 6666 7777  7777 6666 5555 4444 3333 2222 1111 0000
1 a000 a001 a002 a003 a004 a005 a006 a007  a000 a004 a002 a006 a001 a005 a003 a007
# mixed modes on the same data
0 dead beef cafe f00d 1234 5678 9abc def0  dead beef cafe f00d 1234 5678 9abc def0
2 dead beef cafe f00d 1234 5678 9abc def0  def0 9abc 5678 1234 f00d cafe beef dead
1 dead beef cafe f00d 1234 5678 9abc def0  dead 1234 cafe 9abc beef 5678 f00d def0
# walking ones
2 0001 0002 0004 0008 0010 0020 0040 0080  0080 0040 0020 0010 0008 0004 0002 0001
1 0001 0002 0004 0008 0010 0020 0040 0080  0001 0010 0004 0040 0002 0020 0008 0080
0 ffff fffe fffd fffc fffb fffa fff9 fff8  ffff fffe fffd fffc fffb fffa fff9 fff8
1 ffff fffe fffd fffc fffb fffa fff9 fff8  ffff fffb fffd fff9 fffe fffa fffc fff8
2 8000 4000 2000 1000 0800 0400 0200 0100  0100 0200 0400 0800 1000 2000 4000 8000
# alternating bit patterns
0 5a5a a5a5 3c3c c3c3 0f0f f0f0 6969 9696  5a5a a5a5 3c3c c3c3 0f0f f0f0 6969 9696
1 5a5a a5a5 3c3c c3c3 0f0f f0f0 6969 9696  5a5a 0f0f 3c3c 6969 a5a5 f0f0 c3c3 9696
2 5a5a a5a5 3c3c c3c3 0f0f f0f0 6969 9696  9696 6969 f0f0 0f0f c3c3 3c3c a5a5 5a5a
1 1000 2001 3002 4003 5004 6005 7006 8007  1000 5004 3002 7006 2001 6005 4003 8007
0 0123 4567 89ab cdef fedc ba98 7654 3210  0123 4567 89ab cdef fedc ba98 7654 3210
2 0123 4567 89ab cdef fedc ba98 7654 3210  3210 7654 ba98 fedc cdef 89ab 4567 0123

// File: dv/frame_reorder_tb.sv
`timescale 1ns/1ps

module frame_reorder_tb
  import fft_stream_pkg::*;
();

  localparam int    BIT_WIDTH  = 16;
  localparam int    N_SAMPLES  = 8;
  localparam int    IDX_W      = $clog2(N_SAMPLES);
  localparam int    MAX_FRAMES = 64;
  localparam string STIM_FILE  = "dv/frame_reorder_stimulus.txt";

  typedef struct packed {
    logic [BIT_WIDTH-1:0] sample;
    logic [IDX_W-1:0]     index; // slot within the input frame.
  } sample_stream_t;

  logic                 clk;
  logic                 reset;
  logic [BIT_WIDTH-1:0] in_msg;
  permute_mode_e        in_mode;
  logic                 in_val;
  logic                 in_rdy;
  logic [BIT_WIDTH-1:0] out_msg;
  logic                 out_val;
  logic                 out_rdy;

  permute_mode_e        frame_modes [MAX_FRAMES];
  logic [BIT_WIDTH-1:0] in_samples  [MAX_FRAMES][N_SAMPLES];
  logic [BIT_WIDTH-1:0] exp_samples [MAX_FRAMES][N_SAMPLES];
  int                   num_frames  = 0;
  int                   error_count = 0;
  int                   check_count = 0;
  int                   cycle_count = 0;
  int                   cycle_limit = 0;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  frame_reorder_top #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES)
  ) frame_reorder_top_inst (
    .clk     (clk),
    .reset   (reset),
    .in_msg  (in_msg),
    .in_mode (in_mode),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .out_msg (out_msg),
    .out_val (out_val),
    .out_rdy (out_rdy)
  );

  bind frame_reorder_top frame_reorder_assert #(
    .BIT_WIDTH(BIT_WIDTH)
  ) frame_reorder_assert_inst (
    .clk       (clk),
    .reset     (reset),
    .in_rdy    (in_rdy),
    .frame_val (frame_val),
    .frame_rdy (frame_rdy),
    .perm_val  (perm_val),
    .ser_state (sample_serializer_inst.serializer_control_inst.state),
    .out_msg   (out_msg),
    .out_val   (out_val),
    .out_rdy   (out_rdy)
  );

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: frames still incomplete after %0d cycles", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  // ==========================================================================
  // stimulus file and reference order
  // ==========================================================================

  task automatic load_stimulus(output logic ok);
    int    fd;
    int    slot;
    int    word;
    string tok;
    string rest;
    slot = 0;
    fd   = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tok) == 1 && num_frames < MAX_FRAMES) begin
        if (tok.substr(0, 0) == "#") begin
          void'($fgets(rest, fd)); // rest of a comment line.
        end else begin
          void'($sscanf(tok, "%h", word));
          if (slot == 0) begin
            frame_modes[num_frames] = permute_mode_e'(word[1:0]);
          end else if (slot <= N_SAMPLES) begin
            in_samples[num_frames][slot-1] = word[BIT_WIDTH-1:0];
          end else begin
            exp_samples[num_frames][slot-1-N_SAMPLES] = word[BIT_WIDTH-1:0];
          end
          slot = slot + 1;
          if (slot == 2 * N_SAMPLES + 1) begin
            slot       = 0;
            num_frames = num_frames + 1;
          end
        end
      end
      $fclose(fd);
    end
    ok = (fd != 0) && (num_frames > 0) && (slot == 0);
  endtask

  // input slot that lands on output position pos.
  function automatic int source_index(permute_mode_e mode, int pos);
    int rev;
    rev = 0;
    for (int b = 0; b < IDX_W; b++) begin
      if (pos[b]) begin
        rev = rev | (1 << (IDX_W - 1 - b));
      end
    end
    case (mode)
      PERM_BITREV:  return rev;
      PERM_REVERSE: return N_SAMPLES - 1 - pos;
      default:      return pos;
    endcase
  endfunction

  function automatic logic [IDX_W-1:0] locate_sample(int f, logic [BIT_WIDTH-1:0] value);
    logic [IDX_W-1:0] found;
    found = '0;
    for (int i = 0; i < N_SAMPLES; i++) begin
      if (in_samples[f][i] == value) begin
        found = IDX_W'(i);
      end
    end
    return found;
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================

  task automatic check_sample(input string name, input logic [BIT_WIDTH-1:0] got,
                              input logic [BIT_WIDTH-1:0] expected);
    check_count = check_count + 1;
    if (got !== expected) begin
      error_count = error_count + 1;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_mode_frame(input string name, input sample_stream_t got,
                                  input sample_stream_t expected);
    check_count = check_count + 1;
    if (got !== expected) begin
      error_count = error_count + 1;
      $display("[FAIL] %0t ns %s: got %h from slot %0d, expected %h from slot %0d",
               $time, name, got.sample, got.index, expected.sample, expected.index);
    end
  endtask

  // ==========================================================================
  // input driver and output monitor
  // ==========================================================================

  task automatic drive_frames();
    for (int f = 0; f < num_frames; f++) begin
      for (int i = 0; i < N_SAMPLES; i++) begin
        while ($urandom_range(3) == 0) begin
          in_val = 1'b0;
          @(negedge clk);
        end
        in_val  = 1'b1;
        in_msg  = in_samples[f][i];
        in_mode = (i == 0) ? frame_modes[f] : permute_mode_e'($urandom_range(2)); // stray.
        while (!in_rdy) begin
          @(negedge clk);
        end
        @(negedge clk); // taken on the edge in between.
      end
    end
    in_val = 1'b0;
  endtask

  task automatic collect_frames();
    int             pos;
    int             src;
    int             errors_before;
    logic           take;
    sample_stream_t got_s;
    sample_stream_t exp_s;
    for (int f = 0; f < num_frames; f++) begin
      pos           = 0;
      errors_before = error_count;
      while (pos < N_SAMPLES) begin
        take    = ($urandom_range(2) != 0);
        out_rdy = take;
        if (out_val && take) begin
          src          = source_index(frame_modes[f], pos);
          got_s.sample = out_msg;
          got_s.index  = locate_sample(f, out_msg);
          exp_s.sample = in_samples[f][src];
          exp_s.index  = IDX_W'(src);
          check_sample($sformatf("out_msg frame %0d slot %0d", f, pos),
                       out_msg, exp_samples[f][pos]);
          check_mode_frame($sformatf("out_msg frame %0d slot %0d", f, pos), got_s, exp_s);
          pos = pos + 1;
        end
        @(negedge clk);
      end
      if (error_count == errors_before) begin
        $display("frame %0d %s: ok", f, frame_modes[f].name());
      end else begin
        $display("frame %0d %s: %0d mismatches", f, frame_modes[f].name(),
                 error_count - errors_before);
      end
    end
    out_rdy = 1'b0;
  endtask

  // ==========================================================================
  // run
  // ==========================================================================

  initial begin
    logic loaded;
    void'($urandom(32'h9d6590bb));
    reset   = 1'b1;
    in_msg  = '0;
    in_mode = PERM_PASS;
    in_val  = 1'b0;
    out_rdy = 1'b0;
    load_stimulus(loaded);
    if (!loaded) begin
      $display("no complete frame could be read from %s", STIM_FILE);
      $display("test failed");
    end else begin
      cycle_limit = num_frames * N_SAMPLES * 8 + 200;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (out_val !== 1'b0) begin
        error_count = error_count + 1;
        $display("[FAIL] %0t ns out_val: got %b, expected 0 after reset", $time, out_val);
      end
      fork
        drive_frames();
        collect_frames();
      join
      out_rdy = 1'b1;
      repeat (2 * N_SAMPLES) begin
        @(negedge clk);
        if (out_val) begin
          error_count = error_count + 1;
          $display("extra output sample %h after the last frame", out_msg);
        end
      end
      $display("frames %0d, checks %0d, errors %0d", num_frames, check_count, error_count);
      if (error_count == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
    end
    $finish;
  end

endmodule

// File: logic/fft_stream_pkg.sv
package fft_stream_pkg;

  // ==========================================================================
  // frame permutation modes
  // ==========================================================================

  // mode travels with the first sample of a frame.
  typedef enum logic [1:0] {
    PERM_PASS    = 2'd0, // input order.
    PERM_BITREV  = 2'd1, // fft input order.
    PERM_REVERSE = 2'd2  // last sample first.
  } permute_mode_e;

  // ==========================================================================
  // serializer control
  // ==========================================================================

  typedef enum logic {
    SER_LOAD = 1'b0, // waiting on a permuted frame.
    SER_SEND = 1'b1  // draining samples.
  } ser_state_e;

endpackage

// File: logic/frame_permute.sv
`timescale 1ns/1ps

module frame_permute
  import fft_stream_pkg::*;
#(
  parameter int BIT_WIDTH = 16,
  parameter int N_SAMPLES = 8
) (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [BIT_WIDTH*N_SAMPLES-1:0] frame,
  input  permute_mode_e                  frame_mode,
  input  logic                           frame_val,
  output logic                           frame_rdy,

  output logic [BIT_WIDTH*N_SAMPLES-1:0] perm_frame,
  output logic                           perm_val,
  input  logic                           perm_rdy
);

  localparam int IDX_W = $clog2(N_SAMPLES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_SAMPLES - 1);

  logic [BIT_WIDTH*N_SAMPLES-1:0] reordered;
  logic [IDX_W-1:0]               dst_idx;

  // output slot of the sample sitting at idx.
  function automatic logic [IDX_W-1:0] out_slot(input permute_mode_e mode,
                                                input logic [IDX_W-1:0] idx);
    logic [IDX_W-1:0] rev;
    for (int b = 0; b < IDX_W; b++) begin
      rev[b] = idx[IDX_W-1-b];
    end
    case (mode)
      PERM_BITREV:  return rev;
      PERM_REVERSE: return LAST_IDX - idx;
      default:      return idx;
    endcase
  endfunction

  // ==========================================================================
  // index permutation
  // ==========================================================================

  always_comb begin
    reordered = '0;
    dst_idx   = '0;
    for (int i = 0; i < N_SAMPLES; i++) begin
      dst_idx = out_slot(frame_mode, IDX_W'(i));
      reordered[dst_idx*BIT_WIDTH +: BIT_WIDTH] = frame[i*BIT_WIDTH +: BIT_WIDTH];
    end
  end

  // ==========================================================================
  // one-entry pipeline register
  // ==========================================================================

  assign frame_rdy = ~perm_val | perm_rdy; // empty, or draining this cycle.

  always_ff @(posedge clk) begin
    if (reset) begin
      perm_val <= 1'b0;
    end else if (frame_rdy) begin
      perm_val <= frame_val;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_val && frame_rdy) begin
      perm_frame <= reordered;
    end
  end

endmodule

// File: logic/frame_reorder_top.sv
`timescale 1ns/1ps

module frame_reorder_top
  import fft_stream_pkg::*;
#(
  parameter int BIT_WIDTH = 16,
  parameter int N_SAMPLES = 8 // power of two, at least 2.
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic [BIT_WIDTH-1:0] in_msg,
  input  permute_mode_e        in_mode,
  input  logic                 in_val,
  output logic                 in_rdy,

  output logic [BIT_WIDTH-1:0] out_msg,
  output logic                 out_val,
  input  logic                 out_rdy
);

  // deserializer to permuter.
  logic [BIT_WIDTH*N_SAMPLES-1:0] frame;
  permute_mode_e                  frame_mode;
  logic                           frame_val;
  logic                           frame_rdy;

  // permuter to serializer.
  logic [BIT_WIDTH*N_SAMPLES-1:0] perm_frame;
  logic                           perm_val;
  logic                           perm_rdy;

  // ==========================================================================
  // sample in, frame out
  // ==========================================================================

  sample_deserializer #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES)
  ) sample_deserializer_inst (
    .clk        (clk),
    .reset      (reset),
    .in_msg     (in_msg),
    .in_mode    (in_mode),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .frame      (frame),
    .frame_mode (frame_mode),
    .frame_val  (frame_val),
    .frame_rdy  (frame_rdy)
  );

  frame_permute #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES)
  ) frame_permute_inst (
    .clk        (clk),
    .reset      (reset),
    .frame      (frame),
    .frame_mode (frame_mode),
    .frame_val  (frame_val),
    .frame_rdy  (frame_rdy),
    .perm_frame (perm_frame),
    .perm_val   (perm_val),
    .perm_rdy   (perm_rdy)
  );

  // ==========================================================================
  // frame in, sample out
  // ==========================================================================

  sample_serializer #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES)
  ) sample_serializer_inst (
    .clk        (clk),
    .reset      (reset),
    .perm_frame (perm_frame),
    .perm_val   (perm_val),
    .perm_rdy   (perm_rdy),
    .out_msg    (out_msg),
    .out_val    (out_val),
    .out_rdy    (out_rdy)
  );

endmodule

// File: logic/sample_deserializer.sv
`timescale 1ns/1ps

module sample_deserializer
  import fft_stream_pkg::*;
#(
  parameter int BIT_WIDTH = 16,
  parameter int N_SAMPLES = 8
) (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [BIT_WIDTH-1:0]           in_msg,
  input  permute_mode_e                  in_mode,
  input  logic                           in_val,
  output logic                           in_rdy,

  output logic [BIT_WIDTH*N_SAMPLES-1:0] frame,
  output permute_mode_e                  frame_mode,
  output logic                           frame_val,
  input  logic                           frame_rdy
);

  localparam int IDX_W = $clog2(N_SAMPLES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_SAMPLES - 1);

  logic [IDX_W-1:0] fill_cnt; // next slot to write.
  logic             full;
  logic             in_fire;
  logic             frame_fire;

  assign in_rdy     = ~full;
  assign frame_val  = full;
  assign in_fire    = in_val & in_rdy;
  assign frame_fire = frame_val & frame_rdy;

  // ==========================================================================
  // fill counter and full flag
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt <= '0;
      full     <= 1'b0;
    end else begin
      if (in_fire) begin
        if (fill_cnt == LAST_IDX) begin
          fill_cnt <= '0;
          full     <= 1'b1; // frame complete.
        end else begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end
      if (frame_fire) begin
        full <= 1'b0; // handed over, accept again next cycle.
      end
    end
  end

  // ==========================================================================
  // sample slots and mode capture
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (in_fire) begin
      frame[fill_cnt*BIT_WIDTH +: BIT_WIDTH] <= in_msg;
      if (fill_cnt == '0) begin
        frame_mode <= in_mode; // only the first sample carries it.
      end
    end
  end

endmodule

// File: logic/sample_serializer.sv
`timescale 1ns/1ps

module sample_serializer #(
  parameter int BIT_WIDTH = 16,
  parameter int N_SAMPLES = 8
) (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [BIT_WIDTH*N_SAMPLES-1:0] perm_frame,
  input  logic                           perm_val,
  output logic                           perm_rdy,

  output logic [BIT_WIDTH-1:0]           out_msg,
  output logic                           out_val,
  input  logic                           out_rdy
);

  localparam int IDX_W = $clog2(N_SAMPLES);

  logic [BIT_WIDTH*N_SAMPLES-1:0] frame_q;
  logic [IDX_W-1:0]               mux_sel;
  logic                           reg_en;

  always_ff @(posedge clk) begin
    if (reg_en) begin
      frame_q <= perm_frame;
    end
  end

  assign out_msg = frame_q[mux_sel*BIT_WIDTH +: BIT_WIDTH]; // current sample.

  serializer_control #(
    .N_SAMPLES(N_SAMPLES)
  ) serializer_control_inst (
    .clk      (clk),
    .reset    (reset),
    .perm_val (perm_val),
    .perm_rdy (perm_rdy),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .mux_sel  (mux_sel),
    .reg_en   (reg_en)
  );

endmodule

// ============================================================================
// load/send FSM and sample counter
// ============================================================================

module serializer_control
  import fft_stream_pkg::*;
#(
  parameter int N_SAMPLES = 8
) (
  input  logic                         clk,
  input  logic                         reset,

  input  logic                         perm_val,
  output logic                         perm_rdy,

  output logic                         out_val,
  input  logic                         out_rdy,

  output logic [$clog2(N_SAMPLES)-1:0] mux_sel,
  output logic                         reg_en
);

  localparam int IDX_W = $clog2(N_SAMPLES);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_SAMPLES - 1);

  ser_state_e state;
  ser_state_e next_state;
  logic       out_fire;

  assign perm_rdy = (state == SER_LOAD);
  assign out_val  = (state == SER_SEND);
  assign reg_en   = perm_rdy & perm_val;
  assign out_fire = out_val & out_rdy;

  always_comb begin
    next_state = state;
    case (state)
      SER_LOAD: begin
        if (perm_val) begin
          next_state = SER_SEND;
        end
      end
      SER_SEND: begin
        if (out_fire && mux_sel == LAST_IDX) begin
          next_state = SER_LOAD; // last sample taken.
        end
      end
      default: next_state = SER_LOAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= SER_LOAD;
      mux_sel <= '0;
    end else begin
      state <= next_state;
      if (out_fire) begin
        mux_sel <= (mux_sel == LAST_IDX) ? '0 : mux_sel + 1'b1;
      end
    end
  end

endmodule

// File: src.f
logic/fft_stream_pkg.sv
logic/sample_deserializer.sv
logic/frame_permute.sv
logic/sample_serializer.sv
logic/frame_reorder_top.sv
dv/frame_reorder_assert.sv
dv/frame_reorder_tb.sv
